//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_top
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
+incdir+tests
source/noc_pkg.sv
source/flit_fifo.sv
source/vc_arbiter.sv
source/write_read_demux.sv
source/write_unit.sv
source/read_unit.sv
source/response_merger.sv
source/store_ram.sv
source/noc_mem_endpoint.sv
tests/tb_top.sv

//--- source/flit_fifo.sv
module flit_fifo #(
  parameter int FIFO_DEPTH = 4
)(
  input  logic               clk,
  input  logic               rst_n,
  input  noc_pkg::noc_flit_t in_flit,
  input  logic               in_valid,
  output logic               in_ready,
  output noc_pkg::noc_flit_t out_flit,
  output logic               out_valid,
  input  logic               out_ready
);
  import noc_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  noc_flit_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // pointers wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];  // oldest entry sits at the read pointer
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither leaves the level alone
      endcase
    end
  end

endmodule

//--- source/noc_mem_endpoint.sv
module noc_mem_endpoint #(
  parameter int CHANNELS   = 2,
  parameter int FIFO_DEPTH = 4
)(
  input  logic               clk,
  input  logic               rst_n,
  input  noc_pkg::noc_flit_t flit_in,
  input  logic               flit_in_valid,
  output logic               flit_in_ready,
  output noc_pkg::noc_flit_t flit_out,
  output logic               flit_out_valid,
  input  logic               flit_out_ready
);
  import noc_pkg::*;

  noc_flit_t write_flit;
  logic      write_valid;
  logic      write_ready;
  noc_flit_t read_flit;
  logic      read_valid;
  logic      read_ready;
  noc_flit_t wr_resp_flit;
  logic      wr_resp_valid;
  logic      wr_resp_ready;
  noc_flit_t rd_resp_flit;
  logic      rd_resp_valid;
  logic      rd_resp_ready;
  logic      mem_we;
  addr_t     mem_waddr;
  data_t     mem_wdata;
  addr_t     mem_raddr;
  data_t     mem_rdata;

  write_read_demux #(
    .CHANNELS   (CHANNELS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_demux (
    .clk           (clk),
    .rst_n         (rst_n),
    .flit_in       (flit_in),
    .flit_in_valid (flit_in_valid),
    .flit_in_ready (flit_in_ready),
    .write_flit    (write_flit),
    .write_valid   (write_valid),
    .write_ready   (write_ready),
    .read_flit     (read_flit),
    .read_valid    (read_valid),
    .read_ready    (read_ready)
  );

  write_unit u_write_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_flit   (write_flit),
    .req_valid  (write_valid),
    .req_ready  (write_ready),
    .mem_we     (mem_we),
    .mem_waddr  (mem_waddr),
    .mem_wdata  (mem_wdata),
    .resp_flit  (wr_resp_flit),
    .resp_valid (wr_resp_valid),
    .resp_ready (wr_resp_ready)
  );

  read_unit u_read_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_flit   (read_flit),
    .req_valid  (read_valid),
    .req_ready  (read_ready),
    .mem_raddr  (mem_raddr),
    .mem_rdata  (mem_rdata),
    .resp_flit  (rd_resp_flit),
    .resp_valid (rd_resp_valid),
    .resp_ready (rd_resp_ready)
  );

  store_ram u_store (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

  response_merger u_merger (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_flit        (wr_resp_flit),
    .wr_valid       (wr_resp_valid),
    .wr_ready       (wr_resp_ready),
    .rd_flit        (rd_resp_flit),
    .rd_valid       (rd_resp_valid),
    .rd_ready       (rd_resp_ready),
    .flit_out       (flit_out),
    .flit_out_valid (flit_out_valid),
    .flit_out_ready (flit_out_ready)
  );

endmodule

//--- source/noc_pkg.sv
package noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // basic widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [31:0] data_t;  // payload word of every flit
  typedef logic [7:0]  addr_t;  // word address into the local store
  typedef logic [3:0]  len_t;   // beat count, legal range is 1 to 15
  typedef logic [3:0]  tag_t;   // request tag echoed in the response
  typedef logic        vc_t;    // virtual channel number

  // the fourth encoding is never sent and is treated as illegal
  typedef enum logic [1:0] {
    PKT_WRITE    = 2'd0,
    PKT_READ     = 2'd1,
    PKT_RESPONSE = 2'd2
  } packet_type_t;

  typedef enum logic [1:0] {
    RESP_OK = 2'd0
  } resp_status_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit and header layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // 37 bits on the wire, control bits above the payload
  typedef struct packed {
    logic         head;         // first flit of a packet
    logic         tail;         // last flit of a packet
    vc_t          vc;           // virtual channel the packet travels on
    packet_type_t packet_type;  // copied into every flit of the packet
    data_t        payload;      // header on a head flit, data otherwise
  } noc_flit_t;

  // payload of every head flit, status is only meaningful in responses
  typedef struct packed {
    logic [13:0]  rsvd;    // zero on the wire
    resp_status_t status;  // zero in requests
    tag_t         tag;
    len_t         len;
    addr_t        addr;    // first word of the burst
  } noc_header_t;

endpackage

//--- source/read_unit.sv
module read_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  noc_pkg::noc_flit_t req_flit,
  input  logic               req_valid,
  output logic               req_ready,
  output noc_pkg::addr_t     mem_raddr,
  input  noc_pkg::data_t     mem_rdata,
  output noc_pkg::noc_flit_t resp_flit,
  output logic               resp_valid,
  input  logic               resp_ready
);
  import noc_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_HEAD, RD_FETCH, RD_BEAT} rd_state_t;

  rd_state_t   state;
  noc_header_t hdr_q;
  vc_t         vc_q;
  len_t        beat;       // index of the beat being fetched or sent
  logic        last_beat;

  assign req_ready = (state == RD_IDLE);  // one read in flight at a time
  assign last_beat = (beat == hdr_q.len - 1'b1);

  // the address stays put through RD_BEAT so a stalled beat keeps its word
  assign mem_raddr = hdr_q.addr + addr_t'(beat);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response stream
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign resp_valid = (state == RD_HEAD) || (state == RD_BEAT);

  always_comb begin
    resp_flit.head        = (state == RD_HEAD);
    resp_flit.tail        = (state == RD_BEAT) && last_beat;
    resp_flit.vc          = vc_q;
    resp_flit.packet_type = PKT_RESPONSE;
    resp_flit.payload     = (state == RD_HEAD) ? data_t'(hdr_q) : mem_rdata;  // echo header
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      hdr_q <= noc_header_t'(req_flit.payload);
      vc_q  <= req_flit.vc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RD_IDLE;
      beat  <= '0;
    end else begin
      case (state)
        RD_IDLE: if (req_valid && req_flit.head) begin
          state <= RD_HEAD;
        end
        RD_HEAD: if (resp_ready) begin
          state <= RD_FETCH;
          beat  <= '0;
        end
        RD_FETCH: state <= RD_BEAT;  // one cycle of store latency
        RD_BEAT: if (resp_ready) begin
          if (last_beat) begin
            state <= RD_IDLE;
          end else begin
            state <= RD_FETCH;
            beat  <= beat + 1'b1;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

endmodule

//--- source/response_merger.sv
module response_merger (
  input  logic               clk,
  input  logic               rst_n,
  input  noc_pkg::noc_flit_t wr_flit,
  input  logic               wr_valid,
  output logic               wr_ready,
  input  noc_pkg::noc_flit_t rd_flit,
  input  logic               rd_valid,
  output logic               rd_ready,
  output noc_pkg::noc_flit_t flit_out,
  output logic               flit_out_valid,
  input  logic               flit_out_ready
);

  logic locked;     // a packet owns the output
  logic sel_q;      // held source, high for the read side
  logic prefer_rd;  // who goes first when both are waiting
  logic pick_rd;
  logic cur_rd;

  always_comb begin
    if (wr_valid && rd_valid) begin
      pick_rd = prefer_rd;
    end else begin
      pick_rd = rd_valid;
    end
  end

  assign cur_rd         = locked ? sel_q : pick_rd;
  assign flit_out       = cur_rd ? rd_flit : wr_flit;
  assign flit_out_valid = cur_rd ? rd_valid : wr_valid;
  assign wr_ready       = !cur_rd && flit_out_ready;
  assign rd_ready       = cur_rd && flit_out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked    <= 1'b0;
      sel_q     <= 1'b0;
      prefer_rd <= 1'b0;
    end else if (flit_out_valid) begin
      if (flit_out_ready && flit_out.tail) begin
        locked    <= 1'b0;
        prefer_rd <= !cur_rd;  // hand the next turn to the other side
      end else begin
        locked <= 1'b1;
        sel_q  <= cur_rd;
      end
    end
  end

endmodule

//--- source/store_ram.sv
module store_ram (
  input  logic           clk,
  input  logic           we,
  input  noc_pkg::addr_t waddr,
  input  noc_pkg::data_t wdata,
  input  noc_pkg::addr_t raddr,
  output noc_pkg::data_t rdata
);
  import noc_pkg::*;

  localparam int WORDS = 2 ** $bits(addr_t);

  data_t mem [WORDS];

  // read before write when both ports hit the same word
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

//--- source/vc_arbiter.sv
module vc_arbiter #(
  parameter int CHANNELS = 2
)(
  input  logic                clk,
  input  logic                rst_n,
  input  noc_pkg::noc_flit_t  req_flit [CHANNELS],
  input  logic [CHANNELS-1:0] req_valid,
  output logic [CHANNELS-1:0] req_ready,
  output noc_pkg::noc_flit_t  grant_flit,
  output logic                grant_valid,
  input  logic                grant_ready
);

  localparam int IDX_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  logic             locked;     // a packet owns the output
  logic [IDX_W-1:0] lock_idx;
  logic [IDX_W-1:0] last_idx;   // winner of the previous packet
  logic [IDX_W-1:0] rr_pick;
  logic [IDX_W-1:0] grant_idx;

  // scan downwards so the nearest channel after the last winner is kept
  always_comb begin
    rr_pick = last_idx;
    for (int k = CHANNELS; k >= 1; k--) begin
      if (req_valid[(int'(last_idx) + k) % CHANNELS]) begin
        rr_pick = IDX_W'((int'(last_idx) + k) % CHANNELS);
      end
    end
  end

  assign grant_idx   = locked ? lock_idx : rr_pick;
  assign grant_flit  = req_flit[grant_idx];
  assign grant_valid = req_valid[grant_idx];

  always_comb begin
    req_ready            = '0;
    req_ready[grant_idx] = grant_ready;  // only the granted channel sees ready
  end

  // the grant is frozen while a flit waits, and released by the tail transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked   <= 1'b0;
      lock_idx <= '0;
      last_idx <= IDX_W'(CHANNELS - 1);  // channel 0 wins first
    end else if (grant_valid) begin
      if (grant_ready && grant_flit.tail) begin
        locked   <= 1'b0;
        last_idx <= grant_idx;
      end else begin
        locked   <= 1'b1;
        lock_idx <= grant_idx;
      end
    end
  end

endmodule

//--- source/write_read_demux.sv
module write_read_demux #(
  parameter int CHANNELS   = 2,
  parameter int FIFO_DEPTH = 4
)(
  input  logic               clk,
  input  logic               rst_n,
  input  noc_pkg::noc_flit_t flit_in,
  input  logic               flit_in_valid,
  output logic               flit_in_ready,
  output noc_pkg::noc_flit_t write_flit,
  output logic               write_valid,
  input  logic               write_ready,
  output noc_pkg::noc_flit_t read_flit,
  output logic               read_valid,
  input  logic               read_ready
);
  import noc_pkg::*;

  typedef enum logic [1:0] {ROUTE_NONE, ROUTE_WRITE, ROUTE_READ} route_t;

  noc_flit_t           fifo_flit [CHANNELS];
  logic [CHANNELS-1:0] fifo_in_valid;
  logic [CHANNELS-1:0] fifo_in_ready;
  logic [CHANNELS-1:0] fifo_valid;
  logic [CHANNELS-1:0] fifo_ready;
  logic [CHANNELS-1:0] wr_valid;
  logic [CHANNELS-1:0] wr_ready;
  logic [CHANNELS-1:0] rd_valid;
  logic [CHANNELS-1:0] rd_ready;

  function automatic route_t route_of(input packet_type_t packet_type);
    case (packet_type)
      PKT_WRITE: return ROUTE_WRITE;
      PKT_READ:  return ROUTE_READ;
      default:   return ROUTE_NONE;
    endcase
  endfunction

  assign flit_in_ready = fifo_in_ready[flit_in.vc];  // back-pressure per channel

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per channel FIFO and routing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < CHANNELS; i++) begin : g_channel
    logic   start_of_packet;
    route_t route_q;
    route_t route_cur;

    assign fifo_in_valid[i] = flit_in_valid && (int'(flit_in.vc) == i);

    flit_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (flit_in),
      .in_valid  (fifo_in_valid[i]),
      .in_ready  (fifo_in_ready[i]),
      .out_flit  (fifo_flit[i]),
      .out_valid (fifo_valid[i]),
      .out_ready (fifo_ready[i])
    );

    assign start_of_packet = fifo_valid[i] && fifo_flit[i].head;
    assign route_cur = start_of_packet ? route_of(fifo_flit[i].packet_type) : route_q;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        route_q <= ROUTE_NONE;
      end else if (start_of_packet) begin
        route_q <= route_cur;  // held until the next head flit
      end
    end

    assign wr_valid[i]   = fifo_valid[i] && (route_cur == ROUTE_WRITE);
    assign rd_valid[i]   = fifo_valid[i] && (route_cur == ROUTE_READ);
    assign fifo_ready[i] = (route_cur == ROUTE_WRITE) ? wr_ready[i]
                         : (route_cur == ROUTE_READ)  ? rd_ready[i] : 1'b1;  // drop the rest
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one arbiter per direction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  vc_arbiter #(
    .CHANNELS (CHANNELS)
  ) u_write_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_flit    (fifo_flit),
    .req_valid   (wr_valid),
    .req_ready   (wr_ready),
    .grant_flit  (write_flit),
    .grant_valid (write_valid),
    .grant_ready (write_ready)
  );

  vc_arbiter #(
    .CHANNELS (CHANNELS)
  ) u_read_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_flit    (fifo_flit),
    .req_valid   (rd_valid),
    .req_ready   (rd_ready),
    .grant_flit  (read_flit),
    .grant_valid (read_valid),
    .grant_ready (read_ready)
  );

endmodule

//--- source/write_unit.sv
module write_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  noc_pkg::noc_flit_t req_flit,
  input  logic               req_valid,
  output logic               req_ready,
  output logic               mem_we,
  output noc_pkg::addr_t     mem_waddr,
  output noc_pkg::data_t     mem_wdata,
  output noc_pkg::noc_flit_t resp_flit,
  output logic               resp_valid,
  input  logic               resp_ready
);
  import noc_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

  wr_state_t   state;
  noc_header_t hdr_q;
  vc_t         vc_q;
  len_t        beat;      // index of the next data beat
  logic        req_fire;
  noc_header_t resp_hdr;

  assign req_ready = (state != WR_RESP);  // stalls while the response waits
  assign req_fire  = req_valid && req_ready;

  // beat i lands at addr+i, the 8 bit sum wraps around the store
  assign mem_we    = (state == WR_DATA) && req_valid;
  assign mem_waddr = hdr_q.addr + addr_t'(beat);
  assign mem_wdata = req_flit.payload;

  assign resp_hdr   = '{rsvd: '0, status: RESP_OK, tag: hdr_q.tag, len: hdr_q.len,
                        addr: hdr_q.addr};
  assign resp_valid = (state == WR_RESP);
  assign resp_flit  = '{head: 1'b1, tail: 1'b1, vc: vc_q, packet_type: PKT_RESPONSE,
                        payload: data_t'(resp_hdr)};

  always_ff @(posedge clk) begin
    if ((state == WR_IDLE) && req_fire) begin
      hdr_q <= noc_header_t'(req_flit.payload);
      vc_q  <= req_flit.vc;  // the response goes back on the request channel
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= WR_IDLE;
      beat  <= '0;
    end else begin
      case (state)
        WR_IDLE: if (req_fire && req_flit.head) begin
          state <= req_flit.tail ? WR_RESP : WR_DATA;
          beat  <= '0;
        end
        WR_DATA: if (req_fire) begin
          beat <= beat + 1'b1;
          if (req_flit.tail) state <= WR_RESP;
        end
        WR_RESP: if (resp_ready) begin
          state <= WR_IDLE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

endmodule

//--- tests/tb_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checking and bookkeeping
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic check_word(input string name, input data_t exp, input data_t got);
  assert (exp === got) else begin
    $display("[ERROR] %s expected %h actual %h", name, exp, got);
    test_errors++;
  end
endtask

task automatic check_cond(input logic ok, input string msg);
  assert (ok) else begin
    $display("%s", msg);
    test_errors++;
  end
endtask

task automatic finish_test(input string name);
  if (test_errors == 0) begin
    tests_passed++;
    $display("test %s: ok", name);
  end else begin
    tests_failed++;
    $display("test %s: FAILED with %0d errors", name, test_errors);
  end
endtask

function automatic data_t header_word(input tag_t tag, input len_t len, input addr_t addr);
  noc_header_t h;
  h      = '0;
  h.tag  = tag;
  h.len  = len;
  h.addr = addr;
  return data_t'(h);
endfunction

function automatic noc_flit_t make_flit(input logic head, input logic tail, input vc_t vc,
                                        input packet_type_t ptype, input data_t payload);
  noc_flit_t f;
  f.head        = head;
  f.tail        = tail;
  f.vc          = vc;
  f.packet_type = ptype;
  f.payload     = payload;
  return f;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request builders, which also update the reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic build_write(input vc_t vc, input tag_t tag, input len_t len, input addr_t addr);
  data_t w;
  tx_q[vc].push_back(make_flit(1'b1, 1'b0, vc, PKT_WRITE, header_word(tag, len, addr)));
  for (int i = 0; i < len; i++) begin
    w = $urandom;
    ref_mem[addr_t'(addr + i)] = w;  // address wraps around the store
    tx_q[vc].push_back(make_flit(1'b0, i == len - 1, vc, PKT_WRITE, w));
  end
  exp_words[tag] = {header_word(tag, len, addr)};  // single response flit
  exp_used[tag]  = 1'b1;
  exp_vc[tag]    = vc;
  exp_flits++;
endtask

task automatic build_read(input vc_t vc, input tag_t tag, input len_t len, input addr_t addr);
  tx_q[vc].push_back(make_flit(1'b1, 1'b1, vc, PKT_READ, header_word(tag, len, addr)));
  exp_words[tag] = {header_word(tag, len, addr)};
  for (int i = 0; i < len; i++) exp_words[tag].push_back(ref_mem[addr_t'(addr + i)]);
  exp_used[tag] = 1'b1;
  exp_vc[tag]   = vc;
  exp_flits += 1 + len;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// driving
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic offer_flit(input noc_flit_t f, input int limit, output logic ok);
  @(negedge clk);
  flit_in       = f;
  flit_in_valid = 1'b1;
  ok            = 1'b0;
  for (int c = 0; c < limit && !ok; c++) begin
    @(posedge clk);
    ok = flit_in_ready;  // valid stays high until the next flit or idle
  end
endtask

task automatic idle_input();
  @(negedge clk) flit_in_valid = 1'b0;
endtask

// alternates between channels flit by flit while both have traffic
task automatic send_queues();
  int   ch;
  logic ok;
  ch = 0;
  while (tx_q[0].size() + tx_q[1].size() > 0) begin
    if (tx_q[ch].size() > 0) begin
      offer_flit(tx_q[ch].pop_front(), CYCLE_LIMIT, ok);
    end
    ch = 1 - ch;
  end
  idle_input();
endtask

task automatic check_responses();
  int          idx;
  int          n;
  tag_t        tag;
  noc_header_t hdr;
  noc_flit_t   f;
  while (rx_q.size() < exp_flits) @(posedge clk);
  repeat (20) @(posedge clk);  // catch any extra output
  check_word("rx flit count", exp_flits, rx_q.size());
  idx = 0;
  while (idx < rx_q.size()) begin
    hdr = noc_header_t'(rx_q[idx].payload);
    tag = hdr.tag;
    if (!rx_q[idx].head || !exp_used[tag]) begin
      check_cond(1'b0, $sformatf("unexpected flit at output position %0d", idx));
      idx++;
    end else begin
      n = exp_words[tag].size();
      for (int k = 0; k < n && idx < rx_q.size(); k++) begin
        f = rx_q[idx];
        check_word("flit_out.payload", exp_words[tag][k], f.payload);
        check_word("flit_out.head", k == 0, f.head);
        check_word("flit_out.tail", k == n - 1, f.tail);
        check_word("flit_out.vc", exp_vc[tag], f.vc);
        check_word("flit_out.packet_type", PKT_RESPONSE, f.packet_type);
        idx++;
      end
      exp_used[tag] = 1'b0;
    end
  end
  foreach (exp_used[t]) check_cond(!exp_used[t], $sformatf("no response for tag %0d", t));
  rx_q.delete();
  exp_flits = 0;
endtask

//--- tests/tb_tests.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic test_reset_state();
  test_errors = 0;
  @(negedge clk);
  check_word("flit_out_valid", 0, flit_out_valid);
  check_word("flit_in_ready", 1, flit_in_ready);
  finish_test("reset state");
endtask

task automatic test_write_then_read();
  test_errors = 0;
  build_write(0, 4'd1, 4'd5, 8'h10);
  build_read(0, 4'd2, 4'd5, 8'h10);  // same words come back
  send_queues();
  while (rx_q.size() == 0) @(posedge clk);
  check_word("flit_out.payload", header_word(4'd1, 4'd5, 8'h10), rx_q[0].payload);
  check_responses();
  finish_test("write then read");
endtask

task automatic test_interleaved_channels();
  test_errors = 0;
  build_write(0, 4'd3, 4'd4, 8'h40);  // the VC 0 packet ends before the VC 1 FIFO fills
  build_write(1, 4'd4, 4'd8, 8'h60);
  send_queues();
  check_responses();
  build_read(0, 4'd5, 4'd4, 8'h40);
  build_read(1, 4'd6, 4'd8, 8'h60);
  send_queues();
  check_responses();
  finish_test("interleaved channels");
endtask

task automatic test_output_stalls();
  test_errors = 0;
  out_mode = 1;
  build_write(0, 4'd7, 4'd6, 8'h20);
  build_read(1, 4'd8, 4'd8, 8'h60);  // region from the previous test
  send_queues();
  check_responses();
  out_mode = 0;
  finish_test("output stalls");
endtask

task automatic test_dropped_packet();
  logic ok;
  test_errors = 0;
  offer_flit(make_flit(1'b1, 1'b1, 0, PKT_RESPONSE, header_word(4'd9, 4'd2, 8'h10)),
             CYCLE_LIMIT, ok);
  build_write(0, 4'd0, 4'd3, 8'hfe);  // burst wraps past the top of the store
  build_read(0, 4'd10, 4'd3, 8'hfe);
  send_queues();
  check_responses();
  finish_test("dropped packet");
endtask

task automatic test_backpressure();
  logic ok;
  logic stalled;
  test_errors = 0;
  out_mode = 2;
  for (int p = 0; p < 4; p++) build_write(0, tag_t'(11 + p), 4'd4, addr_t'(8'h80 + 4 * p));
  stalled = 1'b0;
  while (tx_q[0].size() > 0 && !stalled) begin
    offer_flit(tx_q[0][0], 10, ok);
    if (ok) begin
      void'(tx_q[0].pop_front());
    end else begin
      stalled = 1'b1;
    end
  end
  check_cond(stalled, "flit_in_ready never fell for VC 0 while the output was held");
  idle_input();
  build_read(1, 4'd15, 4'd4, 8'h60);
  offer_flit(tx_q[1].pop_front(), 10, ok);
  check_cond(ok, "a flit on VC 1 was refused while only VC 0 was full");
  idle_input();
  out_mode = 0;
  send_queues();
  check_responses();
  finish_test("back-pressure");
endtask

//--- tests/tb_top.sv
module tb_top;
  import noc_pkg::*;

  localparam int CHANNELS    = 2;
  localparam int FIFO_DEPTH  = 4;
  localparam int CYCLE_LIMIT = 20000;  // ten times the longest test with stalls

  logic      clk;
  logic      rst_n;
  noc_flit_t flit_in;
  logic      flit_in_valid;
  logic      flit_in_ready;
  noc_flit_t flit_out;
  logic      flit_out_valid;
  logic      flit_out_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // testbench state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  data_t     ref_mem [256];     // reference copy of the store
  noc_flit_t tx_q [2][$];       // pending request flits per virtual channel
  noc_flit_t rx_q [$];          // flits seen on the output
  data_t     exp_words [16][$]; // expected payloads per tag
  logic      exp_used [16];
  vc_t       exp_vc [16];
  int        exp_flits;
  int        out_mode;          // 0 ready high, 1 random stalls, 2 held low
  int        cycle_count;
  int        test_errors;
  int        tests_passed;
  int        tests_failed;

  noc_mem_endpoint #(
    .CHANNELS   (CHANNELS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .flit_in        (flit_in),
    .flit_in_valid  (flit_in_valid),
    .flit_in_ready  (flit_in_ready),
    .flit_out       (flit_out),
    .flit_out_valid (flit_out_valid),
    .flit_out_ready (flit_out_ready)
  );

  `include "tb_tasks.svh"
  `include "tb_tests.svh"

  always #50 clk = ~clk;

  always @(negedge clk) begin
    case (out_mode)
      0:       flit_out_ready = 1'b1;
      1:       flit_out_ready = ($urandom % 3) != 0;  // stall about a third of the time
      default: flit_out_ready = 1'b0;
    endcase
  end

  // output monitor, samples on the edge where the flit transfers
  always @(posedge clk) begin
    if (rst_n && flit_out_valid && flit_out_ready) begin
      rx_q.push_back(flit_out);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(71872));
    clk            = 1'b0;
    rst_n          = 1'b0;
    flit_in        = '0;
    flit_in_valid  = 1'b0;
    flit_out_ready = 1'b1;
    out_mode       = 0;
    cycle_count    = 0;
    exp_flits      = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    foreach (exp_used[i]) exp_used[i] = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;

    test_reset_state();
    test_write_then_read();
    test_interleaved_channels();
    test_output_stalls();
    test_dropped_packet();
    test_backpressure();

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
